// File: design/mosaic_pkg.sv
package mosaic_pkg;

   // Red sits in the upper byte.
   typedef struct packed {
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
   } pixel_t;

   // Code 3 is unnamed and is treated like MODE_PASS.
   typedef enum logic [1:0] {
      MODE_PASS      = 2'd0,
      MODE_MOSAIC    = 2'd1,
      MODE_DARK_MASK = 2'd2
   } mix_mode_t;

   // One word of the tile memory.
   typedef struct packed {
      pixel_t color;
      logic   dark;
   } tile_avg_t;

   // Input pins to output pins, in clock cycles.
   localparam int PIPE_LAT = 2;

   // Approximate luma, (r + 2g + b) / 4.
   function automatic logic [7:0] luma(pixel_t p);
      logic [9:0] sum;
      sum = {2'b00, p.r} + {1'b0, p.g, 1'b0} + {2'b00, p.b};
      return sum[9:2];
   endfunction

endpackage

// File: design/tile_pos_if.sv
`timescale 1ns/1ns

interface tile_pos_if #(
   parameter int H_ACTIVE = 1920,
   parameter int V_ACTIVE = 1080,
   parameter int KH_LOG2  = 4,
   parameter int KV_LOG2  = 3
);

   localparam int HBLKS = H_ACTIVE >> KH_LOG2;
   localparam int VBLKS = V_ACTIVE >> KV_LOG2;
   localparam int HT_W  = (HBLKS > 1) ? $clog2(HBLKS) : 1;
   localparam int VT_W  = (VBLKS > 1) ? $clog2(VBLKS) : 1;

   logic               de;
   logic [HT_W-1:0]    ht;
   logic [VT_W-1:0]    vt;
   logic [KH_LOG2-1:0] px_in_tile_x;
   logic               last_line_of_tile;
   logic               row_done;          // Falling de on the last line of a tile row.
   logic               frame_done;        // Rising vs.

   modport decode (output de, ht, vt, px_in_tile_x, last_line_of_tile, row_done, frame_done);

   modport execute (input de, ht, vt, px_in_tile_x, last_line_of_tile, row_done, frame_done);

   modport result (input de, ht, vt);

endinterface

// File: design/tile_cursor.sv
`timescale 1ns/1ns

module tile_cursor #(
   parameter int H_ACTIVE = 1920,
   parameter int V_ACTIVE = 1080,
   parameter int KH_LOG2  = 4,
   parameter int KV_LOG2  = 3
) (
   input  logic       vin_clk_i,
   input  logic       rst_i,
   input  logic       hs_i,
   input  logic       vs_i,
   input  logic       de_i,
   tile_pos_if.decode pos_o
);

   localparam int HBLKS = H_ACTIVE >> KH_LOG2;
   localparam int VBLKS = V_ACTIVE >> KV_LOG2;
   localparam int HT_W  = (HBLKS > 1) ? $clog2(HBLKS) : 1;
   localparam int VT_W  = (VBLKS > 1) ? $clog2(VBLKS) : 1;
   localparam int X_W   = $clog2(H_ACTIVE + 1);
   localparam int Y_W   = $clog2(V_ACTIVE + 1);

   logic [X_W-1:0]     x_cnt;    // Pixel index of the current input.
   logic [Y_W-1:0]     y_cnt;
   logic               hs_q;
   logic               vs_q;
   logic               de_q;
   logic               de_fall;
   logic               hs_rise;
   logic               vs_rise;
   logic               tile_last_line;
   logic [HT_W-1:0]    ht_q;
   logic [VT_W-1:0]    vt_q;
   logic [KH_LOG2-1:0] px_q;
   logic               last_q;
   logic               row_done_q;
   logic               frame_done_q;

   assign de_fall        = de_q && !de_i;
   assign hs_rise        = hs_i && !hs_q;
   assign vs_rise        = vs_i && !vs_q;
   assign tile_last_line = &y_cnt[KV_LOG2-1:0];

   always_ff @(posedge vin_clk_i) begin
      if (rst_i || vs_rise) begin
         x_cnt <= '0;
         y_cnt <= '0;
      end else begin
         if (de_i)
            x_cnt <= x_cnt + 1'b1;
         else if (de_fall || hs_rise)
            x_cnt <= '0; // Line start, resync on hs too.
         if (de_fall)
            y_cnt <= y_cnt + 1'b1;
      end
   end

   always_ff @(posedge vin_clk_i) begin
      if (rst_i) begin
         hs_q         <= 1'b0;
         vs_q         <= 1'b0;
         de_q         <= 1'b0;
         ht_q         <= '0;
         vt_q         <= '0;
         px_q         <= '0;
         last_q       <= 1'b0;
         row_done_q   <= 1'b0;
         frame_done_q <= 1'b0;
      end else begin
         hs_q         <= hs_i;
         vs_q         <= vs_i;
         de_q         <= de_i;
         ht_q         <= HT_W'(x_cnt >> KH_LOG2);
         vt_q         <= VT_W'(y_cnt >> KV_LOG2); // Still the old row during row_done.
         px_q         <= x_cnt[KH_LOG2-1:0];
         last_q       <= tile_last_line;
         row_done_q   <= de_fall && tile_last_line;
         frame_done_q <= vs_rise;
      end
   end

   assign pos_o.de                = de_q;
   assign pos_o.ht                = ht_q;
   assign pos_o.vt                = vt_q;
   assign pos_o.px_in_tile_x      = px_q;
   assign pos_o.last_line_of_tile = last_q;
   assign pos_o.row_done          = row_done_q;
   assign pos_o.frame_done        = frame_done_q;

endmodule

// File: design/tile_stats.sv
`timescale 1ns/1ns

module tile_stats #(
   parameter int H_ACTIVE = 1920,
   parameter int V_ACTIVE = 1080,
   parameter int KH_LOG2  = 4,
   parameter int KV_LOG2  = 3,
   parameter int DARK_T   = 40,
   localparam int HBLKS   = H_ACTIVE >> KH_LOG2,
   localparam int VBLKS   = V_ACTIVE >> KV_LOG2,
   localparam int TILES   = HBLKS * VBLKS,
   localparam int ADDR_W  = (TILES > 1) ? $clog2(TILES) : 1
) (
   input  logic                  vin_clk_i,
   input  logic                  rst_i,
   tile_pos_if.execute           pos_i,
   input  mosaic_pkg::pixel_t    pix_i,
   input  logic [ADDR_W-1:0]     rd_addr_i,
   output mosaic_pkg::tile_avg_t rd_data_o,
   output logic                  frame_dark_o,
   output logic                  tiles_valid_o
);

   import mosaic_pkg::*;

   localparam int HT_W  = (HBLKS > 1) ? $clog2(HBLKS) : 1;
   localparam int VT_W  = (VBLKS > 1) ? $clog2(VBLKS) : 1;
   localparam int SHIFT = KH_LOG2 + KV_LOG2;
   localparam int SUM_W = 8 + SHIFT;

   logic [SUM_W-1:0] sum_r [HBLKS];
   logic [SUM_W-1:0] sum_g [HBLKS];
   logic [SUM_W-1:0] sum_b [HBLKS];
   tile_avg_t        tile_mem [TILES];

   logic             walk_busy;
   logic             walk_on;
   logic [HT_W-1:0]  walk_col;
   logic [VT_W-1:0]  wr_row;
   logic [ADDR_W-1:0] wr_addr;
   pixel_t           avg;
   logic             avg_dark;
   logic             dark_acc;   // AND of dark flags over the frame.
   logic             frame_full;
   logic             last_pixel;

   // Write-back starts in the row_done cycle itself.
   assign walk_on = pos_i.row_done || walk_busy;

   assign last_pixel = pos_i.de && pos_i.last_line_of_tile &&
                       (pos_i.vt == VT_W'(VBLKS - 1)) &&
                       (pos_i.ht == HT_W'(HBLKS - 1)) && (&pos_i.px_in_tile_x);

   always_comb begin
      avg.r    = sum_r[walk_col][SHIFT +: 8]; // Divide by tile area.
      avg.g    = sum_g[walk_col][SHIFT +: 8];
      avg.b    = sum_b[walk_col][SHIFT +: 8];
      avg_dark = luma(avg) < DARK_T;
      wr_addr  = ADDR_W'(wr_row) * ADDR_W'(HBLKS) + ADDR_W'(walk_col);
   end

   always_ff @(posedge vin_clk_i) begin
      if (rst_i || pos_i.frame_done) begin
         for (int i = 0; i < HBLKS; i++) begin
            sum_r[i] <= '0;
            sum_g[i] <= '0;
            sum_b[i] <= '0;
         end
      end else if (walk_on) begin
         sum_r[walk_col] <= '0;
         sum_g[walk_col] <= '0;
         sum_b[walk_col] <= '0;
      end else if (pos_i.de) begin
         sum_r[pos_i.ht] <= sum_r[pos_i.ht] + SUM_W'(pix_i.r);
         sum_g[pos_i.ht] <= sum_g[pos_i.ht] + SUM_W'(pix_i.g);
         sum_b[pos_i.ht] <= sum_b[pos_i.ht] + SUM_W'(pix_i.b);
      end
   end

   always_ff @(posedge vin_clk_i) begin
      if (rst_i) begin
         walk_busy     <= 1'b0;
         walk_col      <= '0;
         wr_row        <= '0;
         dark_acc      <= 1'b1;
         frame_full    <= 1'b0;
         frame_dark_o  <= 1'b0;
         tiles_valid_o <= 1'b0;
      end else begin
         if (pos_i.de && pos_i.last_line_of_tile)
            wr_row <= pos_i.vt; // vt moves on before the walk ends.
         if (walk_on) begin
            walk_busy <= walk_col != HT_W'(HBLKS - 1);
            walk_col  <= (walk_col == HT_W'(HBLKS - 1)) ? '0 : walk_col + 1'b1;
            dark_acc  <= dark_acc & avg_dark;
         end
         if (last_pixel)
            frame_full <= 1'b1;
         if (pos_i.frame_done) begin
            // A frame counts only once its last pixel was seen.
            if (frame_full) begin
               frame_dark_o  <= dark_acc;
               tiles_valid_o <= 1'b1;
            end
            dark_acc   <= 1'b1;
            frame_full <= 1'b0;
         end
      end
   end

   always_ff @(posedge vin_clk_i) begin
      if (walk_on)
         tile_mem[wr_addr] <= '{color: avg, dark: avg_dark};
      rd_data_o <= tile_mem[rd_addr_i];
   end

endmodule

// File: design/mosaic_mixer.sv
`timescale 1ns/1ns

module mosaic_mixer #(
   parameter int H_ACTIVE = 1920,
   parameter int V_ACTIVE = 1080,
   parameter int KH_LOG2  = 4,
   parameter int KV_LOG2  = 3,
   localparam int HBLKS   = H_ACTIVE >> KH_LOG2,
   localparam int VBLKS   = V_ACTIVE >> KV_LOG2,
   localparam int TILES   = HBLKS * VBLKS,
   localparam int ADDR_W  = (TILES > 1) ? $clog2(TILES) : 1
) (
   input  logic                  vin_clk_i,
   input  logic                  rst_i,
   tile_pos_if.result            pos_i,
   input  mosaic_pkg::pixel_t    pix_i,
   input  logic                  hs_i,
   input  logic                  vs_i,
   input  mosaic_pkg::mix_mode_t mode_i,
   input  logic                  tiles_valid_i,
   output logic [ADDR_W-1:0]     rd_addr_o,
   input  mosaic_pkg::tile_avg_t rd_data_i,
   output logic                  vout_hs_o,
   output logic                  vout_vs_o,
   output logic                  vout_de_o,
   output mosaic_pkg::pixel_t    vout_data_o
);

   import mosaic_pkg::*;

   // The input register in the top takes the first cycle.
   localparam int MIX_DLY = PIPE_LAT - 1;

   typedef struct packed {
      logic      hs;
      logic      vs;
      logic      de;
      logic      valid;
      mix_mode_t mode;
      pixel_t    pix;
   } live_t;

   live_t live_in;
   live_t live_dly [MIX_DLY];
   live_t live_out;

   assign rd_addr_o = ADDR_W'(pos_i.vt) * ADDR_W'(HBLKS) + ADDR_W'(pos_i.ht);

   assign live_in = '{hs: hs_i, vs: vs_i, de: pos_i.de, valid: tiles_valid_i,
                      mode: mode_i, pix: pix_i};

   // Live video waits here for the tile memory read.
   always_ff @(posedge vin_clk_i) begin
      if (rst_i) begin
         for (int i = 0; i < MIX_DLY; i++)
            live_dly[i] <= '0;
      end else begin
         live_dly[0] <= live_in;
         for (int i = 1; i < MIX_DLY; i++)
            live_dly[i] <= live_dly[i-1];
      end
   end

   assign live_out  = live_dly[MIX_DLY-1];
   assign vout_hs_o = live_out.hs;
   assign vout_vs_o = live_out.vs;
   assign vout_de_o = live_out.de;

   always_comb begin
      vout_data_o = '0; // Black outside de.
      if (live_out.de) begin
         vout_data_o = live_out.pix;
         if (live_out.valid) begin
            case (live_out.mode)
               MODE_MOSAIC:    vout_data_o = rd_data_i.color;
               MODE_DARK_MASK: if (rd_data_i.dark) vout_data_o = '0;
               default:        ;
            endcase
         end
      end
   end

endmodule

// File: design/tile_mosaic_top.sv
`timescale 1ns/1ns

module tile_mosaic_top #(
   parameter int H_ACTIVE = 1920,
   parameter int V_ACTIVE = 1080,
   parameter int KH_LOG2  = 4,
   parameter int KV_LOG2  = 3,
   parameter int DARK_T   = 40
) (
   input  logic                  vin_clk_i,
   input  logic                  rst_i,
   input  mosaic_pkg::mix_mode_t mode_i,
   input  logic                  vin_hs_i,
   input  logic                  vin_vs_i,
   input  logic                  vin_de_i,
   input  mosaic_pkg::pixel_t    vin_data_i,
   output logic                  vout_hs_o,
   output logic                  vout_vs_o,
   output logic                  vout_de_o,
   output mosaic_pkg::pixel_t    vout_data_o,
   output logic                  frame_dark_o
);

   import mosaic_pkg::*;

   localparam int HBLKS  = H_ACTIVE >> KH_LOG2;
   localparam int VBLKS  = V_ACTIVE >> KV_LOG2;
   localparam int TILES  = HBLKS * VBLKS;
   localparam int ADDR_W = (TILES > 1) ? $clog2(TILES) : 1;

   logic              hs_q;
   logic              vs_q;
   mix_mode_t         mode_q;
   pixel_t            pix_q;
   logic              tiles_valid;
   logic [ADDR_W-1:0] rd_addr;
   tile_avg_t         rd_data;

   tile_pos_if #(
      .H_ACTIVE (H_ACTIVE),
      .V_ACTIVE (V_ACTIVE),
      .KH_LOG2  (KH_LOG2),
      .KV_LOG2  (KV_LOG2)
   ) u_pos ();

   // Input register, in step with the cursor outputs.
   always_ff @(posedge vin_clk_i) begin
      if (rst_i) begin
         hs_q   <= 1'b0;
         vs_q   <= 1'b0;
         mode_q <= MODE_PASS;
      end else begin
         hs_q   <= vin_hs_i;
         vs_q   <= vin_vs_i;
         mode_q <= mode_i; // Mode goes with its pixel.
      end
   end

   always_ff @(posedge vin_clk_i) pix_q <= vin_data_i;

   tile_cursor #(
      .H_ACTIVE (H_ACTIVE),
      .V_ACTIVE (V_ACTIVE),
      .KH_LOG2  (KH_LOG2),
      .KV_LOG2  (KV_LOG2)
   ) u_tile_cursor (
      .vin_clk_i (vin_clk_i),
      .rst_i     (rst_i),
      .hs_i      (vin_hs_i),
      .vs_i      (vin_vs_i),
      .de_i      (vin_de_i),
      .pos_o     (u_pos)
   );

   tile_stats #(
      .H_ACTIVE (H_ACTIVE),
      .V_ACTIVE (V_ACTIVE),
      .KH_LOG2  (KH_LOG2),
      .KV_LOG2  (KV_LOG2),
      .DARK_T   (DARK_T)
   ) u_tile_stats (
      .vin_clk_i     (vin_clk_i),
      .rst_i         (rst_i),
      .pos_i         (u_pos),
      .pix_i         (pix_q),
      .rd_addr_i     (rd_addr),
      .rd_data_o     (rd_data),
      .frame_dark_o  (frame_dark_o),
      .tiles_valid_o (tiles_valid)
   );

   mosaic_mixer #(
      .H_ACTIVE (H_ACTIVE),
      .V_ACTIVE (V_ACTIVE),
      .KH_LOG2  (KH_LOG2),
      .KV_LOG2  (KV_LOG2)
   ) u_mosaic_mixer (
      .vin_clk_i     (vin_clk_i),
      .rst_i         (rst_i),
      .pos_i         (u_pos),
      .pix_i         (pix_q),
      .hs_i          (hs_q),
      .vs_i          (vs_q),
      .mode_i        (mode_q),
      .tiles_valid_i (tiles_valid),
      .rd_addr_o     (rd_addr),
      .rd_data_i     (rd_data),
      .vout_hs_o     (vout_hs_o),
      .vout_vs_o     (vout_vs_o),
      .vout_de_o     (vout_de_o),
      .vout_data_o   (vout_data_o)
   );

endmodule

// File: tb/tile_mosaic_assertions.sv
`timescale 1ns/1ns

module tile_mosaic_assertions (
   input logic               vin_clk_i,
   input logic               rst_i,
   input logic               vin_de_i,
   input logic               vout_hs_o,
   input logic               vout_vs_o,
   input logic               vout_de_o,
   input mosaic_pkg::pixel_t vout_data_o,
   input logic               frame_dark_o
);

   import mosaic_pkg::*;

   int error_count = 0; // Failed assertions so far.

   de_latency: assert property (@(posedge vin_clk_i) disable iff (rst_i)
      vout_de_o == $past(vin_de_i, PIPE_LAT))
      else begin
         $error("vout_de_o is not vin_de_i delayed by %0d cycles.", PIPE_LAT);
         error_count++;
      end

   // Outputs settle to zero one edge into reset.
   reset_quiet: assert property (@(posedge vin_clk_i)
      rst_i ##1 rst_i |-> !vout_hs_o && !vout_vs_o && !vout_de_o &&
                          vout_data_o == '0 && !frame_dark_o)
      else begin
         $error("Outputs are not zero during reset.");
         error_count++;
      end

   black_blank: assert property (@(posedge vin_clk_i) disable iff (rst_i)
      !vout_de_o |-> vout_data_o == '0)
      else begin
         $error("vout_data_o is not zero outside de.");
         error_count++;
      end

endmodule

bind tile_mosaic_top tile_mosaic_assertions u_tile_mosaic_assertions (
   .vin_clk_i    (vin_clk_i),
   .rst_i        (rst_i),
   .vin_de_i     (vin_de_i),
   .vout_hs_o    (vout_hs_o),
   .vout_vs_o    (vout_vs_o),
   .vout_de_o    (vout_de_o),
   .vout_data_o  (vout_data_o),
   .frame_dark_o (frame_dark_o)
);

// File: tb/tile_mosaic_tb.sv
`timescale 1ns/1ns

module tile_mosaic_tb;

   import mosaic_pkg::*;

   localparam int H_ACTIVE    = 16;
   localparam int V_ACTIVE    = 8;
   localparam int KH_LOG2     = 2;
   localparam int KV_LOG2     = 2;
   localparam int DARK_T      = 40;
   localparam int H_BLANK     = 8;
   localparam int V_BLANK     = 2;
   localparam int HBLKS       = H_ACTIVE >> KH_LOG2;
   localparam int VBLKS       = V_ACTIVE >> KV_LOG2;
   localparam int LINE_LEN    = H_ACTIVE + H_BLANK;
   localparam int FRAME_LINES = V_ACTIVE + V_BLANK;
   localparam int MAX_FRAMES  = 64;

   // Expected output pins for one input cycle.
   typedef struct packed {
      logic   hs;
      logic   vs;
      logic   de;
      logic   dark;
      pixel_t data;
   } video_exp_t;

   logic      vin_clk_i;
   logic      rst_i;
   mix_mode_t mode_i;
   logic      vin_hs_i;
   logic      vin_vs_i;
   logic      vin_de_i;
   pixel_t    vin_data_i;
   logic      vout_hs_o;
   logic      vout_vs_o;
   logic      vout_de_o;
   pixel_t    vout_data_o;
   logic      frame_dark_o;

   mix_mode_t  frm_mode [MAX_FRAMES];
   int         frm_kind [MAX_FRAMES];
   pixel_t     frm_base [MAX_FRAMES];
   logic       frm_dark [MAX_FRAMES];
   int         n_frames;

   int         sum_r [VBLKS][HBLKS];
   int         sum_g [VBLKS][HBLKS];
   int         sum_b [VBLKS][HBLKS];
   tile_avg_t  prev_avg [VBLKS][HBLKS]; // Averages of the last finished frame.
   logic       model_valid;
   logic       last_frame_dark;
   logic       exp_frame_dark;
   video_exp_t exp_hist [PIPE_LAT];

   int cycle_cnt   = 0;
   int cycle_limit = 0;

   tile_mosaic_top #(
      .H_ACTIVE (H_ACTIVE),
      .V_ACTIVE (V_ACTIVE),
      .KH_LOG2  (KH_LOG2),
      .KV_LOG2  (KV_LOG2),
      .DARK_T   (DARK_T)
   ) u_tile_mosaic_top (
      .vin_clk_i    (vin_clk_i),
      .rst_i        (rst_i),
      .mode_i       (mode_i),
      .vin_hs_i     (vin_hs_i),
      .vin_vs_i     (vin_vs_i),
      .vin_de_i     (vin_de_i),
      .vin_data_i   (vin_data_i),
      .vout_hs_o    (vout_hs_o),
      .vout_vs_o    (vout_vs_o),
      .vout_de_o    (vout_de_o),
      .vout_data_o  (vout_data_o),
      .frame_dark_o (frame_dark_o)
   );

   initial begin
      vin_clk_i = 1'b0;
      forever #50 vin_clk_i = ~vin_clk_i;
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "Simulation stopped at the first failure.");
   endtask

   always @(posedge vin_clk_i) begin
      cycle_cnt++;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
         abort_run($sformatf("Timeout: the run did not end within %0d clock cycles.",
                             cycle_limit));
   end

   task automatic compare_pixel(input pixel_t act, input pixel_t exp, input string what);
      if (act !== exp)
         abort_run($sformatf("** Error at %0t ns: %s is %h, expected %h",
                             $time, what, act, exp));
   endtask

   task automatic compare_bit(input logic act, input logic exp, input string what);
      if (act !== exp)
         abort_run($sformatf("** Error at %0t ns: %s is %b, expected %b",
                             $time, what, act, exp));
   endtask

   task automatic compare_avg(input tile_avg_t act, input tile_avg_t exp, input string what);
      if (act !== exp)
         abort_run($sformatf("** Error at %0t ns: %s is %h/%b, expected %h/%b",
                             $time, what, act.color, act.dark, exp.color, exp.dark));
   endtask

   // (r + 2g + b) / 4.
   function automatic int luma_of(pixel_t p);
      return (int'(p.r) + 2 * int'(p.g) + int'(p.b)) / 4;
   endfunction

   function automatic pixel_t gradient_pixel(pixel_t base, int x, int y);
      pixel_t p;
      p.r = base.r + 8'(16 * (x >> KH_LOG2) + (x & ((1 << KH_LOG2) - 1)));
      p.g = base.g + 8'(40 * (y >> KV_LOG2) + 2 * (y & ((1 << KV_LOG2) - 1)));
      p.b = base.b + 8'(4 * (x + y));
      return p;
   endfunction

   // Checks the outputs of two cycles back, then drives one new input cycle.
   task automatic drive_cycle(input logic hs, input logic vs, input logic de,
                              input pixel_t data, input mix_mode_t mode,
                              input int x, input int y);
      video_exp_t e;
      int         tx;
      int         ty;
      @(negedge vin_clk_i);
      if (u_tile_mosaic_top.u_tile_mosaic_assertions.error_count != 0)
         abort_run("A concurrent assertion on the DUT outputs failed.");
      compare_bit(vout_hs_o, exp_hist[PIPE_LAT-1].hs, "vout_hs_o");
      compare_bit(vout_vs_o, exp_hist[PIPE_LAT-1].vs, "vout_vs_o");
      compare_bit(vout_de_o, exp_hist[PIPE_LAT-1].de, "vout_de_o");
      compare_bit(frame_dark_o, exp_hist[PIPE_LAT-1].dark, "frame_dark_o");
      compare_pixel(vout_data_o, exp_hist[PIPE_LAT-1].data, "vout_data_o");
      e = '{hs: hs, vs: vs, de: de, dark: exp_frame_dark, data: '0};
      if (de) begin
         tx = x >> KH_LOG2;
         ty = y >> KV_LOG2;
         e.data = data;
         if (model_valid && mode == MODE_MOSAIC)
            e.data = prev_avg[ty][tx].color;
         else if (model_valid && mode == MODE_DARK_MASK && prev_avg[ty][tx].dark)
            e.data = '0;
         sum_r[ty][tx] += int'(data.r);
         sum_g[ty][tx] += int'(data.g);
         sum_b[ty][tx] += int'(data.b);
      end
      for (int i = PIPE_LAT - 1; i > 0; i--)
         exp_hist[i] = exp_hist[i-1];
      exp_hist[0] = e;
      vin_hs_i   = hs;
      vin_vs_i   = vs;
      vin_de_i   = de;
      vin_data_i = data;
      mode_i     = mode;
   endtask

   task automatic finish_model_frame(input int f);
      tile_avg_t t;
      logic      all_dark;
      all_dark = 1'b1;
      for (int ty = 0; ty < VBLKS; ty++) begin
         for (int tx = 0; tx < HBLKS; tx++) begin
            t.color.r = 8'(sum_r[ty][tx] >> (KH_LOG2 + KV_LOG2)); // Mean over the tile.
            t.color.g = 8'(sum_g[ty][tx] >> (KH_LOG2 + KV_LOG2));
            t.color.b = 8'(sum_b[ty][tx] >> (KH_LOG2 + KV_LOG2));
            t.dark    = luma_of(t.color) < DARK_T;
            all_dark  = all_dark & t.dark;
            prev_avg[ty][tx] = t;
            sum_r[ty][tx] = 0;
            sum_g[ty][tx] = 0;
            sum_b[ty][tx] = 0;
         end
      end
      compare_bit(all_dark, frm_dark[f], $sformatf("model dark flag of frame %0d", f));
      last_frame_dark = all_dark;
      model_valid     = 1'b1;
   endtask

   // Frame layout: vs on line 0, one more blank line, then the active lines.
   task automatic run_frame(input int f, input logic with_video);
      mix_mode_t mode;
      pixel_t    pix;
      logic      hs;
      logic      vs;
      logic      de;
      int        y;
      if (model_valid) begin
         for (int ty = 0; ty < VBLKS; ty++)
            for (int tx = 0; tx < HBLKS; tx++)
               compare_avg(u_tile_mosaic_top.u_tile_stats.tile_mem[ty * HBLKS + tx],
                           prev_avg[ty][tx], $sformatf("tile memory (%0d,%0d)", tx, ty));
         exp_frame_dark = last_frame_dark; // Loaded by the coming vs edge.
      end
      for (int ln = 0; ln < FRAME_LINES; ln++) begin
         for (int col = 0; col < LINE_LEN; col++) begin
            y    = ln - V_BLANK;
            de   = with_video && ln >= V_BLANK && col < H_ACTIVE;
            hs   = col >= H_ACTIVE + 2 && col < H_ACTIVE + 5;
            vs   = ln == 0;
            mode = with_video ? frm_mode[f] : MODE_PASS;
            pix  = '0;
            if (de) begin
               case (frm_kind[f])
                  0: pix = frm_base[f];
                  1: pix = gradient_pixel(frm_base[f], col, y);
                  default: begin
                     pix  = 24'($urandom);
                     mode = mix_mode_t'(2'($urandom)); // Mode changes mid-frame.
                  end
               endcase
            end
            drive_cycle(hs, vs, de, pix, mode, col, y);
         end
      end
      if (with_video)
         finish_model_frame(f);
   endtask

   initial begin
      int          fd;
      int          code;
      int          m;
      int          k;
      int          d;
      logic [23:0] b;
      string       text;
      rst_i      = 1'b1;
      mode_i     = MODE_PASS;
      vin_hs_i   = 1'b0;
      vin_vs_i   = 1'b0;
      vin_de_i   = 1'b0;
      vin_data_i = '0;
      code = $urandom(32'h5342e3af);
      model_valid     = 1'b0;
      last_frame_dark = 1'b0;
      exp_frame_dark  = 1'b0;
      for (int i = 0; i < PIPE_LAT; i++)
         exp_hist[i] = '0;
      for (int ty = 0; ty < VBLKS; ty++) begin
         for (int tx = 0; tx < HBLKS; tx++) begin
            sum_r[ty][tx] = 0;
            sum_g[ty][tx] = 0;
            sum_b[ty][tx] = 0;
         end
      end

      fd = $fopen("tb/tile_mosaic_stimulus.txt", "r");
      if (fd == 0)
         abort_run("Could not open the stimulus file tb/tile_mosaic_stimulus.txt.");
      n_frames = 0;
      while (!$feof(fd)) begin
         text = "";
         code = $fgets(text, fd);
         if (text.len() > 0 && text[0] != "#") begin
            code = $sscanf(text, "%d %d %h %d", m, k, b, d);
            if (code == 4 && n_frames < MAX_FRAMES) begin
               frm_mode[n_frames] = mix_mode_t'(m[1:0]);
               frm_kind[n_frames] = k;
               frm_base[n_frames] = b;
               frm_dark[n_frames] = d != 0;
               n_frames++;
            end
         end
      end
      $fclose(fd);
      if (n_frames == 0)
         abort_run("The stimulus file holds no frames.");
      cycle_limit = 2 * (n_frames + 1) * LINE_LEN * FRAME_LINES;

      repeat (4) @(negedge vin_clk_i);
      rst_i = 1'b0;
      for (int f = 0; f < n_frames; f++)
         run_frame(f, 1'b1);
      run_frame(n_frames, 1'b0); // Closes the last frame.
      repeat (PIPE_LAT)
         drive_cycle(1'b0, 1'b0, 1'b0, '0, MODE_PASS, 0, 0);

      $display("TB PASSED");
      $finish;
   end

endmodule

// File: tb/tile_mosaic_stimulus.txt
# columns: mode pattern base_rgb_hex expected_frame_dark, one frame per line
# mode 0 pass, 1 mosaic, 2 dark mask, 3 pass; pattern 0 flat, 1 gradient, 2 random
1 0 80c040 0
2 0 101010 1
2 0 80c040 0
1 1 000000 0
1 0 404040 0
2 1 000000 0
2 0 c0c0c0 0
0 0 272727 1
0 0 282828 0
1 1 204060 0
2 2 000000 0
1 2 000000 0
3 0 ffffff 0
1 1 000000 0
2 0 000000 1
2 0 202020 1
1 2 000000 0
0 0 101010 1

// File: tile_mosaic.f
design/mosaic_pkg.sv
design/tile_pos_if.sv
design/tile_cursor.sv
design/tile_stats.sv
design/mosaic_mixer.sv
design/tile_mosaic_top.sv
tb/tile_mosaic_assertions.sv
tb/tile_mosaic_tb.sv

// File: Bender.yml
package:
  name: tile_mosaic

sources:
  - design/mosaic_pkg.sv
  - design/tile_pos_if.sv
  - design/tile_cursor.sv
  - design/tile_stats.sv
  - design/mosaic_mixer.sv
  - design/tile_mosaic_top.sv
  - target: simulation
    files:
      - tb/tile_mosaic_assertions.sv
      - tb/tile_mosaic_tb.sv
